/* lspc.f */
lspcPkg.sv
lspcSequencer.sv
lspcCpuRegs.sv
lspcVram.sv
lspcVideoTiming.sv
lspcAutoAnim.sv
lspcTileFetch.sv
lspcTop.sv
tbLspc.sv

/* lspcAutoAnim.sv */
/*
  Frame timer for auto-animation. aaCount steps once every aaSpeed+1 frames.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcAutoAnim (
	input logic clk24M,
	input logic arstN,
	input logic frameStart,
	input logic [7:0] aaSpeed,
	output lspcPkg::aaCountT aaCount
);
	import lspcPkg::*;

	logic [7:0] frameTimer;

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			frameTimer <= 8'd0;
			aaCount <= '0;
		end else if (frameStart) begin
			// Reload on expiry, count wraps at 8
			if (frameTimer == 8'd0) begin
				frameTimer <= aaSpeed;
				aaCount <= aaCount + 3'd1;
			end else begin
				frameTimer <= frameTimer - 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* lspcCpuRegs.sv */
/*
  CPU registers. addrWrite and dataWrite are decoded straight from cpuWe.
  The read latch only changes on a prefetch, reads of index 0 and 1 return it.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcCpuRegs (
	input logic clk24M,
	input logic arstN,
	input lspcPkg::regIndexT cpuAddr,
	input lspcPkg::vramDataT cpuWrData,
	input logic cpuWe,
	input logic cpuRe,
	input logic addrAdvance,
	input logic latchRead,
	input lspcPkg::vramDataT vramRdData,
	input lspcPkg::rasterT raster,
	input lspcPkg::aaCountT aaCount,
	output lspcPkg::vramAddrT vramAddr,
	output lspcPkg::vramDataT vramWrData,
	output logic addrWrite,
	output logic dataWrite,
	output logic aaDisable,
	output logic [7:0] aaSpeed,
	output lspcPkg::vramDataT cpuRdData
);
	import lspcPkg::*;

	vramAddrT vramMod;
	vramDataT readLatch;
	vramDataT rdMux;
	logic modWrite;
	logic modeWrite;

	// Register write decode
	assign addrWrite = cpuWe && (cpuAddr == regVramAddr);
	assign dataWrite = cpuWe && (cpuAddr == regVramRw);
	assign modWrite = cpuWe && (cpuAddr == regVramMod);
	assign modeWrite = cpuWe && (cpuAddr == regLspcMode);

	// Address, modulo and mode
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			vramAddr <= '0;
			vramMod <= '0;
			aaSpeed <= 8'd0;
			aaDisable <= 1'b0;
		end else begin
			// Advance wraps at 16 bits
			if (addrWrite)
				vramAddr <= cpuWrData;
			else if (addrAdvance)
				vramAddr <= vramAddr + vramMod;
			if (modWrite)
				vramMod <= cpuWrData;
			if (modeWrite) begin
				aaSpeed <= cpuWrData[15:8];
				aaDisable <= cpuWrData[3];
			end
		end
	end

	// Write data and prefetch latch
	always_ff @(posedge clk24M) begin
		if (dataWrite)
			vramWrData <= cpuWrData;
		if (latchRead)
			readLatch <= vramRdData;
	end

	// Read mux
	always_comb begin
		case (cpuAddr)
			regVramMod: rdMux = vramMod;
			regLspcMode: rdMux = {raster, 4'b0000, aaCount};
			default: rdMux = readLatch;
		endcase
	end

	// Read data valid the cycle after cpuRe
	always_ff @(posedge clk24M) begin
		if (cpuRe)
			cpuRdData <= rdMux;
	end

endmodule

`default_nettype wire

/* lspcPkg.sv */
/*
  Shared widths, register indices and slot numbers for the sprite/VRAM model.
  A column is 32 clocks long and always starts at a multiple of eight pixels.
*/
`default_nettype none

package lspcPkg;

	// CPU side words
	typedef logic [15:0] vramAddrT;
	typedef logic [15:0] vramDataT;

	// Register select from the CPU address lines
	typedef logic [1:0] regIndexT;

	localparam regIndexT regVramAddr = 2'd0;
	localparam regIndexT regVramRw = 2'd1;
	localparam regIndexT regVramMod = 2'd2;
	localparam regIndexT regLspcMode = 2'd3;

	// Raster position
	typedef logic [8:0] pixelT;
	typedef logic [8:0] rasterT;

	// Auto-animation tile number, wraps at 8
	typedef logic [2:0] aaCountT;

	// Clock position in an eight-pixel column
	typedef logic [4:0] slotT;

	// Sprite attributes on the P bus
	typedef logic [19:0] tileT;
	typedef logic [7:0] paletteT;

	// Fixed fetch slots, first attribute word then second
	localparam slotT fetchSlotWord0 = 5'd0;
	localparam slotT fetchSlotWord1 = 5'd1;

	// CPU owns the port from here to the end of the column
	localparam slotT cpuSlotFirst = 5'd4;

endpackage

`default_nettype wire

/* lspcSequencer.sv */
/*
  Owns the VRAM port schedule. Fetch reads use slots 0 and 1, the CPU slots 4 to 31.
  Only one CPU operation is held at a time, further requests wait on cpuBusy.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcSequencer (
	input logic clk24M,
	input logic arstN,
	input logic addrWrite,
	input logic dataWrite,
	input logic pixelZero,
	output logic pixelEn,
	output logic vramWe,
	output logic cpuRead,
	output logic latchRead,
	output logic addrAdvance,
	output logic fetchRead,
	output logic fetchWord,
	output logic fetchDone,
	output logic cpuBusy
);
	import lspcPkg::*;

	// Pending CPU operation
	localparam logic [2:0] opIdle = 3'd0;
	localparam logic [2:0] opWrite = 3'd1;
	localparam logic [2:0] opAdvance = 3'd2;
	localparam logic [2:0] opRead = 3'd3;
	localparam logic [2:0] opLatch = 3'd4;

	// Second attribute word lands one slot after its read
	localparam slotT fetchSlotDone = slotT'(fetchSlotWord1 + 5'd2);
	// First clock of pixel 1 within the column
	localparam slotT slotPixelOne = 5'd4;

	logic [1:0] phase;
	slotT slot;
	logic [2:0] cpuOp;
	logic cpuSlot;

	// Four clocks per pixel, 32 per column
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			phase <= 2'd0;
			slot <= 5'd0;
		end else begin
			phase <= phase + 2'd1;
			// Pixel 0 ends here, resync the column to the pixel counter
			if (pixelEn && pixelZero)
				slot <= slotPixelOne;
			else
				slot <= slot + 5'd1;
		end
	end

	assign pixelEn = (phase == 2'd3);
	assign cpuSlot = (slot >= cpuSlotFirst);

	// Write, then advance, then prefetch at the (new) address
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			cpuOp <= opIdle;
		end else begin
			case (cpuOp)
				opIdle: begin
					if (dataWrite)
						cpuOp <= opWrite;
					else if (addrWrite)
						cpuOp <= opRead;
				end
				opWrite: begin
					if (cpuSlot)
						cpuOp <= opAdvance;
				end
				opAdvance: cpuOp <= opRead;
				opRead: begin
					if (cpuSlot)
						cpuOp <= opLatch;
				end
				opLatch: cpuOp <= opIdle;
				default: cpuOp <= opIdle;
			endcase
		end
	end

	// CPU port strobes, only inside CPU slots
	assign vramWe = (cpuOp == opWrite) && cpuSlot;
	assign addrAdvance = (cpuOp == opAdvance);
	assign cpuRead = (cpuOp == opRead) && cpuSlot;
	// Read data from the prefetch is on the port now
	assign latchRead = (cpuOp == opLatch);
	assign cpuBusy = (cpuOp != opIdle);

	// Fixed fetch slots
	assign fetchRead = (slot == fetchSlotWord0) || (slot == fetchSlotWord1);
	assign fetchWord = (slot == fetchSlotWord1);
	assign fetchDone = (slot == fetchSlotDone);

endmodule

`default_nettype wire

/* lspcTileFetch.sv */
/*
  Builds the P-bus sprite word from two attribute words read in slots 0 and 1.
  pBusValid is high in slot 3 only, tile, line and palette hold until the next column.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcTileFetch (
	input logic clk24M,
	input logic arstN,
	input logic fetchRead,
	input logic fetchWord,
	input logic fetchDone,
	input logic aaDisable,
	input lspcPkg::vramDataT rdData,
	input lspcPkg::rasterT raster,
	input lspcPkg::aaCountT aaCount,
	output lspcPkg::tileT pBusTile,
	output logic [3:0] pBusLine,
	output lspcPkg::paletteT pBusPal,
	output logic pBusValid
);
	import lspcPkg::*;

	logic word0Ready;
	logic word1Ready;
	logic [15:0] tileLow;
	logic aa3En;
	logic aa2En;
	logic vflip;
	tileT tileRaw;
	tileT tileAa;

	// Read data shows up one clock after the strobe
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			word0Ready <= 1'b0;
			word1Ready <= 1'b0;
		end else begin
			word0Ready <= fetchRead && !fetchWord;
			word1Ready <= fetchRead && fetchWord;
		end
	end

	// Word 1 fields, taken straight off the port
	assign aa3En = rdData[3] && !aaDisable;
	assign aa2En = rdData[2] && !aaDisable;
	assign vflip = rdData[1];
	assign tileRaw = {rdData[7:4], tileLow};

	// aa3 replaces three bits, aa2 only two
	always_comb begin
		tileAa = tileRaw;
		if (aa3En)
			tileAa[2:0] = aaCount;
		else if (aa2En)
			tileAa[1:0] = aaCount[1:0];
	end

	always_ff @(posedge clk24M) begin
		if (word0Ready)
			tileLow <= rdData;
		if (word1Ready) begin
			pBusTile <= tileAa;
			pBusPal <= rdData[15:8];
			// Line within the tile, mirrored on vflip
			pBusLine <= vflip ? ~raster[3:0] : raster[3:0];
		end
	end

	// Set as word 1 lands, dropped at the end of slot 3
	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN)
			pBusValid <= 1'b0;
		else if (word1Ready)
			pBusValid <= 1'b1;
		else if (fetchDone)
			pBusValid <= 1'b0;
	end

endmodule

`default_nettype wire

/* lspcTop.sv */
/*
  CPU-to-VRAM path and sprite tile fetch, all on clk24M with one clock enable.
  The CPU must hold off cpuWe and cpuRe while cpuBusy is high.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcTop #(
	parameter int vramAddrBits = 15,
	parameter int pixelsPerLine = 384,
	parameter int linesPerFrame = 264
) (
	input logic clk24M,
	input logic arstN,
	input lspcPkg::regIndexT cpuAddr,
	input lspcPkg::vramDataT cpuWrData,
	input logic cpuWe,
	input logic cpuRe,
	output lspcPkg::vramDataT cpuRdData,
	output logic cpuBusy,
	output lspcPkg::tileT pBusTile,
	output logic [3:0] pBusLine,
	output lspcPkg::paletteT pBusPal,
	output logic pBusValid,
	output logic hBlank,
	output logic vBlank
);
	import lspcPkg::*;

	// Sequencer strobes
	logic pixelEn;
	logic vramWe;
	logic cpuRead;
	logic latchRead;
	logic addrAdvance;
	logic fetchRead;
	logic fetchWord;
	logic fetchDone;

	// CPU register side
	logic addrWrite;
	logic dataWrite;
	logic aaDisable;
	logic [7:0] aaSpeed;
	vramAddrT vramAddr;
	vramDataT vramWrData;
	vramDataT vramRdData;

	// Raster
	pixelT pixel;
	rasterT raster;
	logic pixelZero;
	logic frameStart;
	aaCountT aaCount;

	lspcSequencer uSequencer (
		.clk24M(clk24M), .arstN(arstN),
		.addrWrite(addrWrite), .dataWrite(dataWrite), .pixelZero(pixelZero),
		.pixelEn(pixelEn), .vramWe(vramWe), .cpuRead(cpuRead), .latchRead(latchRead),
		.addrAdvance(addrAdvance), .fetchRead(fetchRead), .fetchWord(fetchWord),
		.fetchDone(fetchDone), .cpuBusy(cpuBusy)
	);

	lspcCpuRegs uCpuRegs (
		.clk24M(clk24M), .arstN(arstN),
		.cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuWe(cpuWe), .cpuRe(cpuRe),
		.addrAdvance(addrAdvance), .latchRead(latchRead), .vramRdData(vramRdData),
		.raster(raster), .aaCount(aaCount),
		.vramAddr(vramAddr), .vramWrData(vramWrData),
		.addrWrite(addrWrite), .dataWrite(dataWrite), .aaDisable(aaDisable),
		.aaSpeed(aaSpeed), .cpuRdData(cpuRdData)
	);

	lspcVram #(.vramAddrBits(vramAddrBits)) uVram (
		.clk24M(clk24M),
		.cpuAddr(vramAddr), .cpuWrData(vramWrData),
		.vramWe(vramWe), .cpuRead(cpuRead), .fetchRead(fetchRead), .fetchWord(fetchWord),
		.raster(raster), .pixel(pixel), .rdData(vramRdData)
	);

	lspcVideoTiming #(.pixelsPerLine(pixelsPerLine), .linesPerFrame(linesPerFrame)) uTiming (
		.clk24M(clk24M), .arstN(arstN), .pixelEn(pixelEn),
		.pixel(pixel), .raster(raster), .pixelZero(pixelZero), .frameStart(frameStart),
		.hBlank(hBlank), .vBlank(vBlank)
	);

	lspcAutoAnim uAutoAnim (
		.clk24M(clk24M), .arstN(arstN), .frameStart(frameStart),
		.aaSpeed(aaSpeed), .aaCount(aaCount)
	);

	lspcTileFetch uTileFetch (
		.clk24M(clk24M), .arstN(arstN),
		.fetchRead(fetchRead), .fetchWord(fetchWord), .fetchDone(fetchDone),
		.aaDisable(aaDisable), .rdData(vramRdData), .raster(raster), .aaCount(aaCount),
		.pBusTile(pBusTile), .pBusLine(pBusLine), .pBusPal(pBusPal), .pBusValid(pBusValid)
	);

endmodule

`default_nettype wire

/* lspcVideoTiming.sv */
/*
  Pixel and line counters. hBlank starts at pixel 320, vBlank is the last line only.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcVideoTiming #(
	parameter int pixelsPerLine,
	parameter int linesPerFrame
) (
	input logic clk24M,
	input logic arstN,
	input logic pixelEn,
	output lspcPkg::pixelT pixel,
	output lspcPkg::rasterT raster,
	output logic pixelZero,
	output logic frameStart,
	output logic hBlank,
	output logic vBlank
);
	import lspcPkg::*;

	localparam pixelT lastPixel = pixelT'(pixelsPerLine - 1);
	localparam rasterT lastLine = rasterT'(linesPerFrame - 1);
	localparam pixelT hBlankStart = 9'd320;

	logic lineEnd;

	assign lineEnd = pixelEn && (pixel == lastPixel);

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			pixel <= '0;
			raster <= '0;
			frameStart <= 1'b0;
		end else begin
			// High for the first clock of line 0
			frameStart <= lineEnd && (raster == lastLine);
			if (pixelEn)
				pixel <= lineEnd ? '0 : pixel + 9'd1;
			if (lineEnd)
				raster <= (raster == lastLine) ? '0 : raster + 9'd1;
		end
	end

	assign pixelZero = (pixel == '0);
	assign hBlank = (pixel >= hBlankStart);
	assign vBlank = (raster == lastLine);

endmodule

`default_nettype wire

/* lspcVram.sv */
/*
  Single-port VRAM, one cycle read latency. Fetch has the port while fetchRead is high.
  vramAddrBits must be at least 12 so the whole fetch table fits.
*/
`timescale 1ns/10ps
`default_nettype none

module lspcVram #(
	parameter int vramAddrBits
) (
	input logic clk24M,
	input lspcPkg::vramAddrT cpuAddr,
	input lspcPkg::vramDataT cpuWrData,
	input logic vramWe,
	input logic cpuRead,
	input logic fetchRead,
	input logic fetchWord,
	input lspcPkg::rasterT raster,
	input lspcPkg::pixelT pixel,
	output lspcPkg::vramDataT rdData
);
	import lspcPkg::*;

	vramDataT mem [2**vramAddrBits];
	logic [11:0] fetchAddr;
	logic [vramAddrBits-1:0] portAddr;

	// Two words per column, 48 columns x 32 row groups
	assign fetchAddr = {raster[8:4], pixel[8:3], fetchWord};
	assign portAddr = fetchRead ? vramAddrBits'(fetchAddr) : cpuAddr[vramAddrBits-1:0];

	always_ff @(posedge clk24M) begin
		if (vramWe)
			mem[portAddr] <= cpuWrData;
		if (cpuRead || fetchRead)
			rdData <= mem[portAddr];
	end

endmodule

`default_nettype wire

/* tbLspc.sv */
/*
  Testbench for lspcTop with 8-line frames and a 2^15 word VRAM.
  Stimulus comes from a fixed-seed xorshift and is checked against a cycle model.
*/
`timescale 1ns/10ps
`default_nettype none

module tbLspc;
	import lspcPkg::*;

	localparam int vramBits = 15;
	localparam int pixelsPerLine = 384;
	localparam int linesPerFrame = 8;
	localparam int lineClocks = 4 * pixelsPerLine;
	localparam int frameClocks = lineClocks * linesPerFrame;
	localparam int numTests = 5;
	localparam int framesPerTest = 8;
	localparam int busyLimit = 40;
	// 4 ns per clock
	localparam longint watchdogNs = longint'(numTests) * framesPerTest * frameClocks * 2 * 4;

	logic clk24M;
	logic arstN;
	regIndexT cpuAddr;
	vramDataT cpuWrData;
	logic cpuWe;
	logic cpuRe;
	vramDataT cpuRdData;
	logic cpuBusy;
	tileT pBusTile;
	logic [3:0] pBusLine;
	paletteT pBusPal;
	logic pBusValid;
	logic hBlank;
	logic vBlank;

	// Model state
	vramDataT memM [int];
	vramAddrT addrM;
	vramAddrT modM;
	logic [7:0] aaSpeedM;
	logic aaDisM;
	logic [7:0] frameTimerM;
	aaCountT aaCountM;
	// Values seen one clock earlier when the fetch built its word
	aaCountT aaCountPrev;
	logic aaDisPrev;
	logic pbusCheckOn;
	logic [31:0] rngState;
	int tick;
	int frames;
	int errors;
	int checks;
	int testNum;
	int testErrStart;

	lspcTop #(
		.vramAddrBits(vramBits),
		.pixelsPerLine(pixelsPerLine),
		.linesPerFrame(linesPerFrame)
	) UUT (
		.clk24M(clk24M), .arstN(arstN),
		.cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuWe(cpuWe), .cpuRe(cpuRe),
		.cpuRdData(cpuRdData), .cpuBusy(cpuBusy),
		.pBusTile(pBusTile), .pBusLine(pBusLine), .pBusPal(pBusPal),
		.pBusValid(pBusValid), .hBlank(hBlank), .vBlank(vBlank)
	);

	initial begin
		clk24M = 1'b0;
		forever #2 clk24M = ~clk24M;
	end

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// Storage wraps at its depth
	function automatic int memIndex(input vramAddrT a);
		return int'(a) & ((1 << vramBits) - 1);
	endfunction

	// Tile number after auto-animation substitution
	function automatic tileT expectTile(input vramDataT w0, input vramDataT w1,
			input aaCountT aa, input logic dis);
		tileT t;
		t = {w1[7:4], w0};
		if (!dis && w1[3])
			t[2:0] = aa;
		else if (!dis && w1[2])
			t[1:0] = aa[1:0];
		return t;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (cpuBusy && n < busyLimit) begin
			@(posedge clk24M);
			#1;
			n++;
		end
		checks++;
		assert (!cpuBusy)
		else begin
			errors++;
			$display("cpuBusy still high %0d cycles after a CPU access", busyLimit);
		end
	endtask

	task automatic writeReg(input regIndexT idx, input vramDataT data);
		@(posedge clk24M);
		#1;
		cpuAddr = idx;
		cpuWrData = data;
		cpuWe = 1'b1;
		@(posedge clk24M);
		#1;
		cpuWe = 1'b0;
		// Only address and data writes hold the CPU off
		checkValue("cpuBusy", cpuBusy, (idx == regVramAddr) || (idx == regVramRw));
		// Register file took the write on that edge
		case (idx)
			regVramAddr: addrM = data;
			regVramRw: begin
				memM[memIndex(addrM)] = data;
				addrM = addrM + modM;
			end
			regVramMod: modM = data;
			default: begin
				aaSpeedM = data[15:8];
				aaDisM = data[3];
			end
		endcase
		waitIdle();
	endtask

	task automatic readReg(input regIndexT idx, output vramDataT data,
			output vramDataT modeExp);
		@(posedge clk24M);
		#1;
		cpuAddr = idx;
		cpuRe = 1'b1;
		// Model state of the cycle the read mux samples
		modeExp = {rasterT'((tick / lineClocks) % linesPerFrame), 4'b0000, aaCountM};
		@(posedge clk24M);
		#1;
		cpuRe = 1'b0;
		data = cpuRdData;
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = frames + n;
		wait (frames >= target);
		@(posedge clk24M);
		#1;
	endtask

	task automatic endTest(input string name);
		testNum++;
		$display("test %0d %s: %0d errors", testNum, name, errors - testErrStart);
		testErrStart = errors;
	endtask

	// Cycle model of timing, auto-animation and the P bus
	always @(negedge clk24M) begin
		int phaseM;
		int pixM;
		int rasM;
		int idx;
		logic expValid;
		logic [3:0] lineM;
		vramDataT w0;
		vramDataT w1;
		if (!arstN) begin
			tick = 0;
		end else begin
			phaseM = tick % 4;
			pixM = (tick / 4) % pixelsPerLine;
			rasM = (tick / lineClocks) % linesPerFrame;
			// Model vBlank falls here
			if (tick > 0 && tick % frameClocks == 0) begin
				frames++;
				if (frameTimerM == 8'd0) begin
					frameTimerM = aaSpeedM;
					aaCountM = aaCountM + 3'd1;
				end else begin
					frameTimerM = frameTimerM - 8'd1;
				end
			end
			// Slot 3 of each column
			expValid = (phaseM == 3) && (pixM % 8 == 0);
			checkValue("pBusValid", pBusValid, expValid);
			checkValue("vBlank", vBlank, rasM == linesPerFrame - 1);
			checkValue("hBlank", hBlank, pixM >= 320);
			if (expValid && pbusCheckOn) begin
				idx = ((rasM / 16) << 7) | ((pixM / 8) << 1);
				w0 = memM[idx];
				w1 = memM[idx + 1];
				lineM = 4'(rasM);
				if (w1[1])
					lineM = ~lineM;
				checkValue("pBusTile", pBusTile, expectTile(w0, w1, aaCountPrev, aaDisPrev));
				checkValue("pBusLine", pBusLine, lineM);
				checkValue("pBusPal", pBusPal, w1[15:8]);
			end
			aaCountPrev = aaCountM;
			aaDisPrev = aaDisM;
			tick++;
		end
	end

	initial begin
		vramDataT data;
		vramDataT modeExp;
		vramAddrT baseAddr;
		vramAddrT wordAddr;
		logic [7:0] speed;
		arstN = 1'b0;
		cpuAddr = regVramAddr;
		cpuWrData = '0;
		cpuWe = 1'b0;
		cpuRe = 1'b0;
		addrM = '0;
		modM = '0;
		aaSpeedM = 8'd0;
		aaDisM = 1'b0;
		frameTimerM = 8'd0;
		aaCountM = '0;
		aaCountPrev = '0;
		aaDisPrev = 1'b0;
		pbusCheckOn = 1'b0;
		rngState = 32'ha21a_a54e;
		tick = 0;
		frames = 0;
		errors = 0;
		checks = 0;
		testNum = 0;
		testErrStart = 0;
		wordAddr = '0;
		repeat (8) @(posedge clk24M);
		checkValue("cpuBusy", cpuBusy, 1'b0);
		checkValue("pBusValid", pBusValid, 1'b0);
		checkValue("vBlank", vBlank, 1'b0);
		#1;
		arstN = 1'b1;
		readReg(regLspcMode, data, modeExp);
		checkValue("cpuRdData", data, modeExp);
		checkValue("aaCount", data[2:0], 3'd0);
		endTest("reset state");

		// Address, modulo and data writes with prefetch
		for (int i = 0; i < 16; i++) begin
			baseAddr = vramAddrT'(nextRandom());
			writeReg(regVramAddr, baseAddr);
			writeReg(regVramMod, vramDataT'(nextRandom() & 32'h7));
			for (int j = 0; j < 4; j++) begin
				writeReg(regVramRw, vramDataT'(nextRandom()));
				readReg(regVramRw, data, modeExp);
				if (memM.exists(memIndex(addrM)))
					checkValue("cpuRdData", data, memM[memIndex(addrM)]);
			end
			// Read back every word at its model address
			for (int k = 0; k < 4; k++) begin
				wordAddr = baseAddr + vramAddrT'(k) * modM;
				writeReg(regVramAddr, wordAddr);
				readReg(regVramRw, data, modeExp);
				checkValue("cpuRdData", data, memM[memIndex(wordAddr)]);
			end
			readReg(regVramAddr, data, modeExp);
			checkValue("cpuRdData", data, memM[memIndex(wordAddr)]);
		end
		endTest("vram access");

		for (int i = 0; i < 8; i++) begin
			writeReg(regVramMod, vramDataT'(nextRandom()));
			readReg(regVramMod, data, modeExp);
			checkValue("cpuRdData", data, modM);
			readReg(regLspcMode, data, modeExp);
			checkValue("cpuRdData", data, modeExp);
		end
		endTest("register reads");

		// Two words for each of the 48 columns of row group 0
		writeReg(regVramMod, 16'd1);
		writeReg(regVramAddr, 16'd0);
		for (int c = 0; c < 96; c++)
			writeReg(regVramRw, vramDataT'(nextRandom()));
		pbusCheckOn = 1'b1;
		waitFrames(2);
		endTest("tile fetch");

		for (int s = 0; s < 3; s++) begin
			speed = 8'(nextRandom() & 32'h3);
			writeReg(regLspcMode, {speed, 8'h00});
			waitFrames(5);
			readReg(regLspcMode, data, modeExp);
			checkValue("cpuRdData", data, modeExp);
		end
		// Substitution must stop once the disable bit is set
		writeReg(regLspcMode, 16'h0008);
		waitFrames(2);
		endTest("auto-animation");

		$display("%0d tests, %0d checks, %0d errors", testNum, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
